//--- hw/ppu_vram_settings.svh
`ifndef PPU_VRAM_SETTINGS_SVH
`define PPU_VRAM_SETTINGS_SVH

// memory sizes in bytes
`define PPU_PATTERN_DEPTH   8192
`define PPU_NAMETABLE_DEPTH 2048

// map layout
`define PPU_NAMETABLE_START 16'h2000
`define PPU_NAMETABLE_FOLD  16'h2FFF

// one logical nametable
`define PPU_NAMETABLE_PAGE  1024

`endif

//--- hw/ppu_bus_pkg.sv
package ppu_bus_pkg;

    // ppu side of the video memory bus

    typedef logic [15:0] ppu_addr_t;    // full 16 bit ppu address space
    typedef logic [7:0]  ppu_data_t;    // one vram byte

    // one bus access as the ppu drives it
    typedef struct packed {
        ppu_addr_t addr;                // address being accessed
        logic      rd_n;                // 0 when ppu is reading
        logic      wr_n;                // 0 when ppu is writing
        ppu_data_t wdata;               // write byte, ignored on reads
    } ppu_access_t;                     // 26 bits

    localparam ppu_access_t PPU_ACCESS_IDLE = '{
        addr:  '0,
        rd_n:  1'b1,
        wr_n:  1'b1,
        wdata: '0
    };                                  // both enables released

endpackage : ppu_bus_pkg

//--- hw/ppu_map_pkg.sv
package ppu_map_pkg;

    // memory map side, what the decoder hands to each memory

    typedef enum logic {
        REGION_PATTERN   = 1'b0,        // 0x0000 - 0x1fff
        REGION_NAMETABLE = 1'b1         // 0x2000 and up, folded
    } vram_region_e;

    typedef enum logic {
        MIRROR_HORIZONTAL = 1'b0,       // tables 0/1 and 2/3 share a page
        MIRROR_VERTICAL   = 1'b1        // tables 0/2 and 1/3 share a page
    } mirror_mode_e;

    // request seen by a single memory
    typedef struct packed {
        logic                  cs;      // 1 when this memory is selected
        logic                  rd;      // 1 = read, 0 = write
        ppu_bus_pkg::ppu_addr_t addr;   // already folded for the target
        ppu_bus_pkg::ppu_data_t wdata;  // byte to store on a write
    } mem_access_t;                     // 26 bits

    localparam logic MEM_RD = 1'b1;     // direction encodings
    localparam logic MEM_WR = 1'b0;

endpackage : ppu_map_pkg

//--- hw/ppu_memory_map.sv
`timescale 1ns/1ps

`include "ppu_vram_settings.svh"

module ppu_memory_map (
    input  ppu_bus_pkg::ppu_access_t i_access,         // access from the ppu
    input  ppu_bus_pkg::ppu_data_t   i_pattern_rdata,  // byte read from pattern ram
    input  ppu_bus_pkg::ppu_data_t   i_nametable_rdata,// byte read from nametable vram
    output ppu_map_pkg::mem_access_t o_pattern_req,    // request to pattern ram
    output ppu_map_pkg::mem_access_t o_nametable_req,  // request to nametable vram
    output ppu_bus_pkg::ppu_data_t   o_rdata           // byte back to the ppu
);

    import ppu_bus_pkg::*;
    import ppu_map_pkg::*;

    vram_region_e w_region;             // which memory the address hits
    logic         w_active;             // any enable asserted
    logic         w_rd;                 // direction for both memories
    ppu_addr_t    w_addr;               // address after folding

    assign w_active = ~i_access.rd_n | ~i_access.wr_n;
    assign w_rd     = ~i_access.rd_n ? MEM_RD : MEM_WR;   // read wins if both low

    always_comb
    begin
        if (i_access.addr < `PPU_NAMETABLE_START)
        begin
            w_region = REGION_PATTERN;
            w_addr   = i_access.addr;                      // passes straight through
            o_rdata  = i_pattern_rdata;
        end
        else
        begin
            w_region = REGION_NAMETABLE;
            w_addr   = i_access.addr & `PPU_NAMETABLE_FOLD; // 0x3xxx folds to 0x2xxx
            o_rdata  = i_nametable_rdata;
        end
    end

    always_comb
    begin
        o_pattern_req.cs    = w_active && (w_region == REGION_PATTERN);
        o_pattern_req.rd    = w_rd;
        o_pattern_req.addr  = w_addr;
        o_pattern_req.wdata = i_access.wdata;
    end

    always_comb
    begin
        o_nametable_req.cs    = w_active && (w_region == REGION_NAMETABLE);
        o_nametable_req.rd    = w_rd;
        o_nametable_req.addr  = w_addr;
        o_nametable_req.wdata = i_access.wdata;
    end

endmodule : ppu_memory_map

//--- hw/ppu_pattern_table.sv
`timescale 1ns/1ps

`include "ppu_vram_settings.svh"

module ppu_pattern_table (
    input  logic                     i_clk,
    input  logic                     i_rst_n,  // writes held off while low
    input  ppu_map_pkg::mem_access_t i_req,    // request from the decoder
    output ppu_bus_pkg::ppu_data_t   o_rdata   // combinational read byte
);

    import ppu_bus_pkg::*;

    localparam int unsigned DEPTH  = `PPU_PATTERN_DEPTH;
    localparam int unsigned ADDR_W = $clog2(DEPTH);   // 13 bits for 8 KiB

    ppu_data_t             r_mem [DEPTH];   // tile pattern storage, no reset
    logic [ADDR_W-1:0]     w_index;         // byte index into r_mem
    logic                  w_wr_en;         // selected and writing

    assign w_index = i_req.addr[ADDR_W-1:0];  // decoder keeps addr below 0x2000
    assign w_wr_en = i_req.cs && !i_req.rd && i_rst_n;

    // single port write on the rising edge
    always_ff @(posedge i_clk)
    begin
        if (w_wr_en)
        begin
            r_mem[w_index] <= i_req.wdata;
        end
    end

    // read is asynchronous, same index as the write
    assign o_rdata = r_mem[w_index];

endmodule : ppu_pattern_table

//--- hw/ppu_nametable.sv
`timescale 1ns/1ps

`include "ppu_vram_settings.svh"

module ppu_nametable (
    input  logic                      i_clk,
    input  logic                      i_rst_n,  // writes held off while low
    input  ppu_map_pkg::mem_access_t  i_req,    // folded request from decoder
    input  ppu_map_pkg::mirror_mode_e i_mirror, // static cartridge level
    output ppu_bus_pkg::ppu_data_t    o_rdata   // combinational read byte
);

    import ppu_bus_pkg::*;
    import ppu_map_pkg::*;

    localparam int unsigned DEPTH  = `PPU_NAMETABLE_DEPTH;
    localparam int unsigned ADDR_W = $clog2(DEPTH);                 // 11 bits
    localparam int unsigned PAGE_W = $clog2(`PPU_NAMETABLE_PAGE);   // 10 bits

    ppu_data_t          r_mem [DEPTH];  // two physical 1 KiB pages
    logic [1:0]         w_table;        // logical table 0..3
    logic               w_page;         // physical page after mirroring
    logic [ADDR_W-1:0]  w_index;        // byte index into r_mem
    logic               w_wr_en;        // selected and writing

    // addr bits 11:10 pick one of the four logical tables
    assign w_table = i_req.addr[PAGE_W+1:PAGE_W];

    always_comb
    begin
        if (i_mirror == MIRROR_VERTICAL)
        begin
            w_page = w_table[0];        // 0,2 -> page 0 and 1,3 -> page 1
        end
        else
        begin
            w_page = w_table[1];        // 0,1 -> page 0 and 2,3 -> page 1
        end
    end

    assign w_index = {w_page, i_req.addr[PAGE_W-1:0]};   // page + offset in table
    assign w_wr_en = i_req.cs && !i_req.rd && i_rst_n;

    always_ff @(posedge i_clk)
    begin
        if (w_wr_en)
        begin
            r_mem[w_index] <= i_req.wdata;  // lands on this edge
        end
    end

    // mirrored tables read the same physical byte
    assign o_rdata = r_mem[w_index];

endmodule : ppu_nametable

//--- hw/ppu_vram_subsystem.sv
`timescale 1ns/1ps

module ppu_vram_subsystem (
    input  logic                      i_clk,
    input  logic                      i_rst_n,   // active low, async
    input  ppu_bus_pkg::ppu_access_t  i_access,  // ppu bus access
    input  ppu_map_pkg::mirror_mode_e i_mirror,  // cartridge mirroring level
    output ppu_bus_pkg::ppu_data_t    o_rdata    // read byte to the ppu
);

    import ppu_bus_pkg::*;
    import ppu_map_pkg::*;

    mem_access_t w_pattern_req;     // decoder -> pattern ram
    mem_access_t w_nametable_req;   // decoder -> nametable vram
    ppu_data_t   w_pattern_rdata;   // pattern ram -> decoder
    ppu_data_t   w_nametable_rdata; // nametable vram -> decoder

    // address decode and read data return
    ppu_memory_map u_memory_map (
        .i_access          (i_access),
        .i_pattern_rdata   (w_pattern_rdata),
        .i_nametable_rdata (w_nametable_rdata),
        .o_pattern_req     (w_pattern_req),
        .o_nametable_req   (w_nametable_req),
        .o_rdata           (o_rdata)
    );

    // 0x0000 - 0x1fff
    ppu_pattern_table u_pattern_table (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_req   (w_pattern_req),
        .o_rdata (w_pattern_rdata)
    );

    // 0x2000 and up, mirrored onto 2 KiB
    ppu_nametable u_nametable (
        .i_clk    (i_clk),
        .i_rst_n  (i_rst_n),
        .i_req    (w_nametable_req),
        .i_mirror (i_mirror),
        .o_rdata  (w_nametable_rdata)
    );

endmodule : ppu_vram_subsystem

//--- tb/tb_ppu_vram.sv
`timescale 1ns/1ps

module tb_ppu_vram;

    import ppu_bus_pkg::*;
    import ppu_map_pkg::*;

    localparam int    CLK_PERIOD   = 100;               // ns
    localparam int    RESET_CYCLES = 8;                 // i_rst_n low this many edges
    localparam int    DRIVE_DELAY  = 1;                 // ns after the rising edge
    localparam int    SAMPLE_DELAY = CLK_PERIOD - 2;    // drive to just before next edge
    localparam string TRACE_FILE   = "tb/ppu_vram_trace.txt";

    logic         clk;
    logic         rst_n;
    ppu_access_t  access;           // bus access into the dut
    mirror_mode_e mirror;           // cartridge mirroring level
    ppu_data_t    rdata;            // combinational read byte

    logic [7:0]   trace_op   [$];   // W, R or M
    ppu_addr_t    trace_addr [$];
    ppu_data_t    trace_data [$];   // write byte, or mode bit on an M line
    ppu_data_t    trace_exp  [$];   // expected byte on an R line

    int           data_errors;      // read mismatches
    int           trace_errors;     // file, format and op problems
    int           cycle_count;
    int           cycle_limit;
    logic         trace_loaded;     // limit is valid once set

    ppu_vram_subsystem i_dut (
        .i_clk    (clk),
        .i_rst_n  (rst_n),
        .i_access (access),
        .i_mirror (mirror),
        .o_rdata  (rdata)
    );

    initial
    begin
        clk = 1'b0;
        forever
        begin
            #(CLK_PERIOD / 2) clk = ~clk;
        end
    end

    // trace starts with reset still low, so its first lines hit the write gate
    initial
    begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #(DRIVE_DELAY) rst_n = 1'b1;
    end

    task automatic check_rdata(input ppu_addr_t addr, input ppu_data_t actual,
                               input ppu_data_t expected);
        if (actual !== expected)
        begin
            data_errors++;
            $display("ERR %0t: read at 0x%04h returned 0x%02h, expected 0x%02h",
                     $time, addr, actual, expected);
        end
    endtask

    task automatic print_error_counts();
        $display("errors: %0d read mismatches, %0d trace problems",
                 data_errors, trace_errors);
    endtask

    task automatic load_trace();
        int               fd;
        int               code;
        logic [7:0]       op;
        ppu_addr_t        addr;
        ppu_data_t        data;
        ppu_data_t        expected;
        logic [8*128-1:0] rest;         // remainder of a comment line
        fd = $fopen(TRACE_FILE, "r");
        if (fd == 0)
        begin
            trace_errors++;
            $display("could not open the trace file %s", TRACE_FILE);
            return;
        end
        while (!$feof(fd))
        begin
            code = $fscanf(fd, " %c", op);
            if (code != 1)
            begin
                break;                  // end of file
            end
            if (op == "#")
            begin
                code = $fgets(rest, fd);
            end
            else
            begin
                code = $fscanf(fd, "%h %h %h", addr, data, expected);
                if (code != 3)
                begin
                    trace_errors++;
                    $display("a trace line starting with %c is missing fields", op);
                    break;
                end
                trace_op.push_back(op);
                trace_addr.push_back(addr);
                trace_data.push_back(data);
                trace_exp.push_back(expected);
            end
        end
        $fclose(fd);
    endtask

    task automatic wait_drive_slot();
        @(posedge clk);
        #(DRIVE_DELAY);
    endtask

    // one line takes two cycles, the access and then an idle bus
    task automatic apply_line(input int idx);
        logic [7:0] op;
        ppu_data_t  data;
        op   = trace_op[idx];
        data = trace_data[idx];
        wait_drive_slot();
        case (op)
            "W":
            begin
                access = '{addr: trace_addr[idx], rd_n: 1'b1, wr_n: 1'b0, wdata: data};
            end
            "R":
            begin
                access = '{addr: trace_addr[idx], rd_n: 1'b0, wr_n: 1'b1, wdata: '0};
                #(SAMPLE_DELAY);        // read data settled, edge not yet reached
                check_rdata(trace_addr[idx], rdata, trace_exp[idx]);
            end
            "M":
            begin
                mirror = mirror_mode_e'(data[0]);   // 0 horizontal, 1 vertical
            end
            default:
            begin
                trace_errors++;
                $display("trace entry %0d has an unknown operation %c", idx, op);
            end
        endcase
        wait_drive_slot();
        access = PPU_ACCESS_IDLE;       // both enables back high
    endtask

    initial
    begin
        access       = PPU_ACCESS_IDLE;
        mirror       = MIRROR_VERTICAL;
        data_errors  = 0;
        trace_errors = 0;
        trace_loaded = 1'b0;
        cycle_limit  = 0;
        load_trace();
        if (trace_op.size() == 0 && trace_errors == 0)
        begin
            trace_errors++;
            $display("the trace file holds no accesses");
        end
        cycle_limit  = trace_op.size() * 2 + 50;
        trace_loaded = 1'b1;
        for (int i = 0; i < trace_op.size(); i++)
        begin
            apply_line(i);
        end
        print_error_counts();
        if (data_errors == 0 && trace_errors == 0)
        begin
            $display("STATUS: PASS");
        end
        else
        begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

    // watchdog, sized from the trace length
    initial
    begin
        cycle_count = 0;
        wait (trace_loaded);
        while (cycle_count < cycle_limit)
        begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout: the trace did not finish within %0d cycles", cycle_limit);
        print_error_counts();
        $display("STATUS: FAIL");
        $finish;
    end

endmodule : tb_ppu_vram

//--- tb/ppu_vram_trace.txt
# columns: op addr data expect, all hex; W write, R read, M mirror (data 0 horiz, 1 vert)
# each line takes two cycles, so the first four land while reset is held
W 0100 11 00
W 2300 22 00
W 0100 33 00
W 2300 44 00
# reset released, rewrite and read back
W 0100 a5 00
W 2300 5a 00
R 0100 00 a5
R 2300 00 5a
# pattern ram round trip
W 0000 01 00
W 0fff 02 00
W 1fff 03 00
R 0000 00 01
R 0fff 00 02
R 1fff 00 03
# vertical mirroring
W 2005 c1 00
W 2405 c2 00
R 2805 00 c1
R 2c05 00 c2
R 2005 00 c1
R 2405 00 c2
# pattern write leaves the nametable alone
W 0005 77 00
R 2005 00 c1
R 0005 00 77
R 3005 00 c1
# horizontal mirroring
M 0000 00 00
W 2010 d1 00
W 2810 d2 00
R 2410 00 d1
R 2c10 00 d2
R 2010 00 d1
R 2810 00 d2
W 2455 f4 00
R 2455 00 f4
# write through the fold
W 3810 e3 00
R 2810 00 e3
R 2c10 00 e3
R 2010 00 d1

//--- build.f
+incdir+hw
hw/ppu_bus_pkg.sv
hw/ppu_map_pkg.sv
hw/ppu_memory_map.sv
hw/ppu_pattern_table.sv
hw/ppu_nametable.sv
hw/ppu_vram_subsystem.sv
tb/tb_ppu_vram.sv

//--- Makefile
# Verilator build and run for the PPU video memory subsystem

VERILATOR ?= verilator
TOP       ?= tb_ppu_vram
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FILELIST  ?= build.f
VFLAGS    ?= --binary

SIM     := $(BUILD_DIR)/V$(TOP)
SOURCES := $(wildcard hw/*.sv hw/*.svh tb/*.sv)

.PHONY: all compile run check clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	$(SIM) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@$(MAKE) --no-print-directory check LOG=$(LOG)

check:
	@if grep -q "STATUS: PASS" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
